//--- pkt_macros.svh
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// word and switch geometry
`define PKT_WIDTH        6
`define NUM_DEST         2   // egress fifos

// 4 words per fifo
`define FIFO_ADDR_WIDTH  2

// destination comes from the top bits of the word
`define DEST_WIDTH       1

`endif

//--- pkt_pkg.sv
`include "pkt_macros.svh"

package pkt_pkg;

    // one switch word, destination in its msbs
    typedef logic [`PKT_WIDTH-1:0] pkt_word_t;

    // index of an egress fifo
    typedef logic [`DEST_WIDTH-1:0] dest_idx_t;

endpackage

//--- fifo_pkg.sv
`include "pkt_macros.svh"

package fifo_pkg;

    typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_ptr_t;   // rd/wr pointers

    // one extra bit so a full fifo is distinct from empty
    typedef logic [`FIFO_ADDR_WIDTH:0] fifo_count_t;

    typedef logic [`FIFO_ADDR_WIDTH:0] fifo_thresh_t;  // almost full level

endpackage

//--- fifo_ram.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module fifo_ram
    import pkt_pkg::*;
    import fifo_pkg::*;
(
    input  logic      clk,
    input  logic      write,
    input  fifo_ptr_t wr_ptr,
    input  fifo_ptr_t rd_ptr,
    input  pkt_word_t data_in,
    output pkt_word_t data_out
);

    localparam int DEPTH = 1 << `FIFO_ADDR_WIDTH;

    pkt_word_t mem [DEPTH];

    // write port, registered
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // read port is async, the fifo registers it on pop
    assign data_out = mem[rd_ptr];

endmodule

//--- dest_fifo.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module dest_fifo
    import pkt_pkg::*;
    import fifo_pkg::*;
(
    input  logic         clk,
    input  logic         reset_L,
    input  logic         push,
    input  logic         pop,
    input  pkt_word_t    push_data,
    input  fifo_thresh_t af_thresh,
    output logic         empty,
    output logic         pause,
    output logic         error,
    output pkt_word_t    pop_data
);

    localparam int DEPTH = 1 << `FIFO_ADDR_WIDTH;

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        full;
    logic        push_ok;
    logic        pop_ok;
    pkt_word_t   ram_rd_data;

    fifo_ram u_fifo_ram (
        .clk      (clk),
        .write    (push_ok),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (push_data),
        .data_out (ram_rd_data)
    );

    // status straight off the count
    assign empty = (count == '0);
    assign full  = (count == fifo_count_t'(DEPTH));
    assign pause = (count >= af_thresh);

    // bad requests are flagged and dropped
    assign error   = (push && full) || (pop && empty);
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // every accepted pop loads the output word even with a push alongside
    always_ff @(posedge clk) begin
        if (pop_ok) begin
            pop_data <= ram_rd_data;
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!reset_L)
        count <= fifo_count_t'(DEPTH)
    ) else $error("fifo count above depth");

    // pointer distance tracks the count modulo the depth
    a_ptrs_match_count: assert property (
        @(posedge clk) disable iff (!reset_L)
        fifo_ptr_t'(wr_ptr - rd_ptr) == fifo_ptr_t'(count)
    ) else $error("fifo pointers disagree with count");

endmodule

//--- pkt_router.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module pkt_router
    import pkt_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_L,
    input  logic                 push_in,
    input  pkt_word_t            data_in,
    output logic [`NUM_DEST-1:0] fifo_push,
    output pkt_word_t            fifo_data
);

    logic      push_q;
    pkt_word_t data_q;
    dest_idx_t dest;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            push_q <= 1'b0;
        end else begin
            push_q <= push_in;
        end
    end

    // word held for the push cycle
    always_ff @(posedge clk) begin
        if (push_in) begin
            data_q <= data_in;
        end
    end

    assign dest      = data_q[`PKT_WIDTH-1 -: `DEST_WIDTH];   // top bits pick the fifo
    assign fifo_data = data_q;

    // one-hot strobe toward the chosen fifo
    always_comb begin
        fifo_push = '0;
        if (push_q) begin
            fifo_push[dest] = 1'b1;
        end
    end

    a_push_follows_input: assert property (
        @(posedge clk) disable iff (!reset_L)
        push_in |=> $onehot(fifo_push) && (fifo_data == $past(data_in))
    ) else $error("router lost a pushed word");

endmodule

//--- pkt_arbiter.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module pkt_arbiter
    import pkt_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset_L,
    input  logic                            stall,
    input  logic [`NUM_DEST-1:0]            fifo_empty,
    input  pkt_word_t [`NUM_DEST-1:0]       pop_data_bus,
    output logic [`NUM_DEST-1:0]            fifo_pop,
    output logic                            valid_out,
    output pkt_word_t                       data_out,
    output dest_idx_t                       dest_out
);

    dest_idx_t last_q;        // last granted fifo and output select
    dest_idx_t grant_idx;
    logic      grant_found;
    logic      grant;
    logic      valid_q;

    // first non-empty fifo cyclically after the last grant
    always_comb begin
        dest_idx_t cand;
        grant_found = 1'b0;
        grant_idx   = last_q;
        for (int i = 1; i <= `NUM_DEST; i++) begin
            cand = dest_idx_t'((int'(last_q) + i) % `NUM_DEST);
            if (!grant_found && !fifo_empty[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    assign grant = grant_found && !stall;   // stall holds everything

    always_comb begin
        fifo_pop = '0;
        if (grant) begin
            fifo_pop[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            last_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= grant;
            if (grant) begin
                last_q <= grant_idx;
            end
        end
    end

    // pop_data was loaded by the fifo on the same edge as valid_q
    assign valid_out = valid_q;
    assign data_out  = pop_data_bus[last_q];
    assign dest_out  = last_q;

    a_pop_when_ready: assert property (
        @(posedge clk) disable iff (!reset_L)
        (!stall && !(&fifo_empty)) |-> $onehot(fifo_pop)
    ) else $error("arbiter idles with a fifo ready");

    a_no_pop_on_empty: assert property (
        @(posedge clk) disable iff (!reset_L)
        (fifo_pop & fifo_empty) == '0
    ) else $error("arbiter pops an empty fifo");

endmodule

//--- pkt_switch_top.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module pkt_switch_top
    import pkt_pkg::*;
    import fifo_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_L,
    input  logic                 push_in,
    input  pkt_word_t            data_in,
    input  fifo_thresh_t         af_thresh,
    input  logic                 stall,
    output logic                 pause,
    output logic                 valid_out,
    output pkt_word_t            data_out,
    output dest_idx_t            dest_out,
    output logic [`NUM_DEST-1:0] fifo_error
);

    logic [`NUM_DEST-1:0]      fifo_push;
    pkt_word_t                 fifo_data;
    logic [`NUM_DEST-1:0]      fifo_pop;
    logic [`NUM_DEST-1:0]      fifo_empty;
    logic [`NUM_DEST-1:0]      fifo_pause;
    pkt_word_t [`NUM_DEST-1:0] pop_data_bus;

    pkt_router u_pkt_router (
        .clk       (clk),
        .reset_L   (reset_L),
        .push_in   (push_in),
        .data_in   (data_in),
        .fifo_push (fifo_push),
        .fifo_data (fifo_data)
    );

    for (genvar g = 0; g < `NUM_DEST; g++) begin : g_fifo
        dest_fifo u_dest_fifo (
            .clk       (clk),
            .reset_L   (reset_L),
            .push      (fifo_push[g]),
            .pop       (fifo_pop[g]),
            .push_data (fifo_data),    // shared, push strobe selects
            .af_thresh (af_thresh),
            .empty     (fifo_empty[g]),
            .pause     (fifo_pause[g]),
            .error     (fifo_error[g]),
            .pop_data  (pop_data_bus[g])
        );
    end

    assign pause = |fifo_pause;   // any fifo near full stops upstream

    pkt_arbiter u_pkt_arbiter (
        .clk          (clk),
        .reset_L      (reset_L),
        .stall        (stall),
        .fifo_empty   (fifo_empty),
        .pop_data_bus (pop_data_bus),
        .fifo_pop     (fifo_pop),
        .valid_out    (valid_out),
        .data_out     (data_out),
        .dest_out     (dest_out)
    );

endmodule

//--- tb_pkt_switch.sv
`timescale 1ns/100ps

`include "pkt_macros.svh"

module tb_pkt_switch
    import pkt_pkg::*;
    import fifo_pkg::*;
();

    localparam int DEPTH      = 1 << `FIFO_ADDR_WIDTH;
    localparam int MAX_CYCLES = 4000;   // ~1500 stimulus cycles plus drain, doubled

    logic                 clk;
    logic                 reset_L;
    logic                 push_in;
    pkt_word_t            data_in;
    fifo_thresh_t         af_thresh;
    logic                 stall;
    logic                 pause;
    logic                 valid_out;
    pkt_word_t            data_out;
    dest_idx_t            dest_out;
    logic [`NUM_DEST-1:0] fifo_error;

    pkt_word_t model_q [`NUM_DEST][$];   // words held per destination
    logic      s1_v = 1'b0;              // word the router samples
    pkt_word_t s1_w = '0;
    logic      s2_v = 1'b0;              // word landing in its fifo
    pkt_word_t s2_w = '0;
    logic      stall_prev = 1'b0;
    dest_idx_t last_dest = '0;
    logic      have_last = 1'b0;
    int        checks = 0;
    int        errors = 0;
    int        accepted = 0;
    int        dropped = 0;
    int        words_out = 0;
    int        err_hits = 0;
    int        rr_checks = 0;
    int        cycle_count = 0;

    pkt_switch_top u_pkt_switch_top (
        .clk        (clk),
        .reset_L    (reset_L),
        .push_in    (push_in),
        .data_in    (data_in),
        .af_thresh  (af_thresh),
        .stall      (stall),
        .pause      (pause),
        .valid_out  (valid_out),
        .data_out   (data_out),
        .dest_out   (dest_out),
        .fifo_error (fifo_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic dest_idx_t word_dest(pkt_word_t w);
        return w[`PKT_WIDTH-1 -: `DEST_WIDTH];   // msb picks the fifo
    endfunction

    function automatic logic model_busy();
        logic busy;
        busy = s1_v || s2_v;
        for (int i = 0; i < `NUM_DEST; i++) begin
            busy = busy || (model_q[i].size() != 0);
        end
        return busy;
    endfunction

    task automatic flag_mismatch(string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic drive(input logic v, input pkt_word_t w, input logic st);
        @(posedge clk);
        push_in <= v;
        data_in <= w;
        stall   <= st;
    endtask

    task automatic wait_drain();
        drive(1'b0, '0, 1'b0);
        while (model_busy()) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(int num, string name, int start_err);
        if (errors == start_err) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - start_err);
        end
    endtask

    // model runs mid-cycle, after the edge it accounts for
    always @(negedge clk) begin : monitor
        logic      any_busy;
        logic      both_busy;
        logic      acc;
        logic      exp_err;
        logic      exp_pause;
        dest_idx_t d;
        if (reset_L) begin
            any_busy  = 1'b0;
            both_busy = 1'b1;
            for (int i = 0; i < `NUM_DEST; i++) begin
                any_busy  = any_busy || (model_q[i].size() != 0);
                both_busy = both_busy && (model_q[i].size() != 0);
            end
            d   = word_dest(s2_w);
            acc = s2_v && (model_q[d].size() < DEPTH);   // full fifo drops it
            if (acc) begin
                accepted++;
            end else if (s2_v) begin
                dropped++;
            end
            checks++;
            if (stall_prev && valid_out) begin
                flag_mismatch("valid_out raised after a stalled cycle");
            end else if (!stall_prev && any_busy && !valid_out) begin
                flag_mismatch("no word popped although a fifo held one");
            end
            if (valid_out) begin
                checks++;
                if (model_q[dest_out].size() == 0) begin
                    flag_mismatch($sformatf("word %h from empty dest %0d", data_out, dest_out));
                end else begin
                    if (data_out !== model_q[dest_out][0] || word_dest(data_out) !== dest_out) begin
                        flag_mismatch($sformatf("got %h dest %0d, expected %h", data_out,
                                                dest_out, model_q[dest_out][0]));
                    end
                    void'(model_q[dest_out].pop_front());
                end
                if (both_busy && have_last) begin
                    rr_checks++;
                    if (dest_out == last_dest) begin
                        flag_mismatch($sformatf("dest %0d granted twice in a row", dest_out));
                    end
                end
                last_dest = dest_out;
                have_last = 1'b1;
                words_out++;
            end
            if (acc) begin
                model_q[d].push_back(s2_w);
            end
            s2_v       = s1_v;
            s2_w       = s1_w;
            s1_v       = push_in;
            s1_w       = data_in;
            stall_prev = stall;
            exp_pause  = 1'b0;
            for (int i = 0; i < `NUM_DEST; i++) begin
                exp_err   = s2_v && (word_dest(s2_w) == i) && (model_q[i].size() == DEPTH);
                exp_pause = exp_pause || (model_q[i].size() >= af_thresh);
                checks++;
                if (fifo_error[i] !== exp_err) begin
                    flag_mismatch($sformatf("fifo_error[%0d] is %b, expected %b", i,
                                            fifo_error[i], exp_err));
                end
                if (fifo_error[i]) begin
                    err_hits++;
                end
            end
            checks++;
            if (pause !== exp_pause) begin
                flag_mismatch($sformatf("pause is %b, expected %b", pause, exp_pause));
            end
        end
    end

    initial begin : stimulus
        int        start_err;
        int        base_drop;
        int        base_err;
        int        base_rr;
        int        len;
        pkt_word_t w;
        void'($urandom(32'hd995_f38f));
        reset_L   = 1'b0;
        push_in   = 1'b0;
        data_in   = '0;
        af_thresh = fifo_thresh_t'(DEPTH);
        stall     = 1'b0;
        repeat (2) @(posedge clk);
        reset_L <= 1'b1;

        start_err = errors;
        af_thresh <= fifo_thresh_t'(1 + $urandom % 4);
        repeat (400) drive($urandom % 100 < 60, pkt_word_t'($urandom), 1'b0);
        wait_drain();
        report_test(1, "random traffic", start_err);

        start_err = errors;
        checks++;
        if (words_out != accepted) begin
            flag_mismatch($sformatf("%0d words out, %0d accepted", words_out, accepted));
        end
        report_test(2, "drain count", start_err);

        start_err = errors;
        repeat (6) begin
            len = 5 + $urandom % 26;
            repeat (len) drive(($urandom % 2) == 1, pkt_word_t'($urandom), 1'b1);
            len = 10 + $urandom % 20;
            repeat (len) drive($urandom % 100 < 30, pkt_word_t'($urandom), 1'b0);
        end
        wait_drain();
        report_test(3, "stall hold", start_err);

        start_err = errors;
        repeat (8) begin
            @(posedge clk);
            af_thresh <= fifo_thresh_t'(1 + $urandom % 4);
            repeat (30) drive($urandom % 100 < 40, pkt_word_t'($urandom), 1'b1);
            wait_drain();
        end
        report_test(4, "pause level", start_err);

        // 7 words per fifo under stall, 3 of each must drop
        start_err = errors;
        base_drop = dropped;
        base_err  = err_hits;
        for (int i = 0; i < 14; i++) begin
            w = pkt_word_t'($urandom);
            w[`PKT_WIDTH-1 -: `DEST_WIDTH] = dest_idx_t'(i / 7);
            drive(1'b1, w, 1'b1);
        end
        repeat (2) drive(1'b0, '0, 1'b1);
        wait_drain();
        checks++;
        if (dropped - base_drop != 2 * (7 - DEPTH) || err_hits - base_err != 2 * (7 - DEPTH)) begin
            flag_mismatch($sformatf("%0d drops and %0d error cycles, expected %0d each",
                                    dropped - base_drop, err_hits - base_err, 2 * (7 - DEPTH)));
        end
        report_test(5, "overflow drop", start_err);

        start_err = errors;
        base_rr   = rr_checks;
        for (int i = 0; i < 2 * DEPTH; i++) begin
            w = pkt_word_t'($urandom);
            w[`PKT_WIDTH-1 -: `DEST_WIDTH] = dest_idx_t'(i % 2);
            drive(1'b1, w, 1'b1);
        end
        repeat (2) drive(1'b0, '0, 1'b1);
        wait_drain();
        checks++;
        if (rr_checks - base_rr < 2 * DEPTH - 1) begin
            flag_mismatch($sformatf("only %0d alternation checks", rr_checks - base_rr));
        end
        report_test(6, "round robin", start_err);

        $display("checks %0d, errors %0d, accepted %0d, dropped %0d, words out %0d",
                 checks, errors, accepted, dropped, words_out);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
pkt_pkg.sv
fifo_pkg.sv
fifo_ram.sv
dest_fifo.sv
pkt_router.sv
pkt_arbiter.sv
pkt_switch_top.sv
tb_pkt_switch.sv

//--- Bender.yml
package:
  name: pkt_switch

sources:
  - include_dirs:
      - .
    files:
      - pkt_pkg.sv
      - fifo_pkg.sv
      - fifo_ram.sv
      - dest_fifo.sv
      - pkt_router.sv
      - pkt_arbiter.sv
      - pkt_switch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pkt_switch.sv
